// File: bench/pipelineCpuTb.sv
`timescale 1ns/100ps

module pipelineCpuTb;

    logic                               clk;
    logic                               rstN;
    logic                               progWe;
    logic [cpuPkg::IMEM_ADDR_WIDTH-1:0] progAddr;
    logic [cpuPkg::DATA_WIDTH-1:0]      progData;
    logic                               wbValid;
    logic [cpuPkg::REG_ADDR_WIDTH-1:0]  wbReg;
    logic [cpuPkg::DATA_WIDTH-1:0]      wbData;

    logic [31:0] prog [cpuPkg::IMEM_WORDS];   // program image
    int          progLen;
    integer      seed;
    logic [4:0]  expReg [$];                   // expected writes in program order
    logic [31:0] expData [$];
    int          gotCount;                     // writebacks seen so far
    int          checkCount;
    int          compareErrors;                // checker process only
    int          runErrors;                    // main process only
    int          cycles;
    int          limit;

    pipelineCpu pipelineCpu_inst
    (
        .clk      (clk),
        .rstN     (rstN),
        .progWe   (progWe),
        .progAddr (progAddr),
        .progData (progData),
        .wbValid  (wbValid),
        .wbReg    (wbReg),
        .wbData   (wbData)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;   // 10 ns
    end

    // mips r-type layout
    function automatic logic [31:0] rTypeWord(input cpuPkg::functT fn, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [4:0] rd);
        return {cpuPkg::RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    // i-type layout with a 16-bit immediate
    function automatic logic [31:0] iTypeWord(input cpuPkg::opcodeT op, input logic [4:0] rs,
                                              input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic appendWord(input logic [31:0] word);
        prog[progLen] = word;
        progLen++;
    endtask

    task automatic buildProgram();
        logic [31:0] r;
        appendWord(iTypeWord(cpuPkg::ADDI, 5'd0, 5'd1, 16'd5));       // r1 = 5
        appendWord(iTypeWord(cpuPkg::ADDI, 5'd0, 5'd2, 16'hfffd));    // r2 = -3
        appendWord(rTypeWord(cpuPkg::ADD, 5'd1, 5'd2, 5'd3));         // depends on r2
        appendWord(rTypeWord(cpuPkg::SUB, 5'd1, 5'd2, 5'd4));
        appendWord(iTypeWord(cpuPkg::ADDI, 5'd0, 5'd5, 16'h7fff));
        appendWord(rTypeWord(cpuPkg::MUL, 5'd5, 5'd5, 5'd6));
        appendWord(rTypeWord(cpuPkg::MUL, 5'd6, 5'd6, 5'd7));         // product overflows
        appendWord(iTypeWord(cpuPkg::ADDI, 5'd1, 5'd0, 16'd7));       // r0 gets no writeback
        appendWord(iTypeWord(cpuPkg::SW, 5'd0, 5'd4, 16'd16));
        appendWord(iTypeWord(cpuPkg::LW, 5'd0, 5'd8, 16'd16));        // reads stored word
        appendWord(rTypeWord(cpuPkg::ADD, 5'd8, 5'd1, 5'd9));         // load-use
        appendWord(iTypeWord(cpuPkg::LW, 5'd0, 5'd10, 16'd40));       // never written
        appendWord(iTypeWord(cpuPkg::BEQ, 5'd1, 5'd1, 16'd2));        // taken
        appendWord(iTypeWord(cpuPkg::ADDI, 5'd0, 5'd11, 16'd99));     // skipped
        appendWord(iTypeWord(cpuPkg::ADDI, 5'd0, 5'd12, 16'd98));     // skipped
        appendWord(iTypeWord(cpuPkg::BEQ, 5'd1, 5'd2, 16'd1));        // not taken
        appendWord(iTypeWord(cpuPkg::ADDI, 5'd0, 5'd13, 16'd77));
        appendWord(iTypeWord(cpuPkg::ADDI, 5'd13, 5'd14, 16'd1));
        // random alu section over r0..r15
        for (int i = 0; i < 20; i++)
        begin
            r = $random(seed);
            case (r[1:0])
                2'd0: appendWord(rTypeWord(cpuPkg::ADD, {1'b0, r[5:2]}, {1'b0, r[9:6]},
                                           {1'b0, r[13:10]}));
                2'd1: appendWord(rTypeWord(cpuPkg::SUB, {1'b0, r[5:2]}, {1'b0, r[9:6]},
                                           {1'b0, r[13:10]}));
                2'd2: appendWord(rTypeWord(cpuPkg::MUL, {1'b0, r[5:2]}, {1'b0, r[9:6]},
                                           {1'b0, r[13:10]}));
                default: appendWord(iTypeWord(cpuPkg::ADDI, {1'b0, r[5:2]}, {1'b0, r[13:10]},
                                              r[31:16]));
            endcase
        end
    endtask

    // instruction-set model that walks the program until pc leaves it
    function automatic void runRef();
        logic [31:0] regs [32];
        logic [31:0] mem [cpuPkg::DMEM_WORDS];
        logic [31:0] pc;
        logic [31:0] nextPc;
        logic [31:0] instr;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] value;
        logic [31:0] addr;
        logic [4:0]  dest;
        logic        write;
        int          idx;
        int          steps;
        for (int i = 0; i < 32; i++)
            regs[i] = '0;
        for (int i = 0; i < cpuPkg::DMEM_WORDS; i++)
            mem[i] = '0;
        pc    = '0;
        steps = 0;
        while (int'(pc >> 2) < progLen && steps < 1000)   // step cap guards a loop
        begin
            instr  = prog[int'(pc >> 2)];
            a      = regs[instr[25:21]];
            b      = regs[instr[20:16]];
            imm    = {{16{instr[15]}}, instr[15:0]};
            addr   = a + imm;
            idx    = int'(addr[31:2]) % cpuPkg::DMEM_WORDS;   // word index wraps
            nextPc = pc + 32'd4;
            write  = 1'b0;
            dest   = instr[20:16];
            value  = '0;
            case (instr[31:26])
                cpuPkg::RTYPE:
                begin
                    dest = instr[15:11];
                    case (instr[5:0])
                        cpuPkg::ADD: {write, value} = {1'b1, a + b};
                        cpuPkg::SUB: {write, value} = {1'b1, a - b};
                        cpuPkg::MUL: {write, value} = {1'b1, a * b};   // low word only
                        default:     write = 1'b0;
                    endcase
                end
                cpuPkg::ADDI: {write, value} = {1'b1, a + imm};
                cpuPkg::LW:   {write, value} = {1'b1, mem[idx]};
                cpuPkg::SW:   mem[idx] = b;
                cpuPkg::BEQ:
                begin
                    if (a == b)
                        nextPc = pc + 32'd4 + (imm << 2);
                end
                default: write = 1'b0;
            endcase
            if (write && dest != 5'd0)
            begin
                regs[dest] = value;
                expReg.push_back(dest);
                expData.push_back(value);
            end
            pc = nextPc;
            steps++;
        end
    endfunction

    // load port works only with the core held in reset
    task automatic loadProgram();
        for (int i = 0; i < progLen; i++)
        begin
            @(posedge clk);
            #1;
            progWe   = 1'b1;
            progAddr = cpuPkg::IMEM_ADDR_WIDTH'(i);
            progData = prog[i];
        end
        @(posedge clk);
        #1;
        progWe = 1'b0;
        repeat (8) @(posedge clk);   // 8 more reset cycles after the load
        #1;
        rstN = 1'b1;
    endtask

    // compare each writeback against the model in order
    always @(negedge clk)
    begin
        if (rstN)
        begin
            if (wbValid !== 1'b0 && wbValid !== 1'b1)
            begin
                $display("writeback strobe is unknown at %0t", $time);
                compareErrors++;
            end
            else if (wbValid)
            begin
                if (gotCount >= expReg.size())
                begin
                    $display("unexpected extra writeback to r%0d with %h at %0t",
                             wbReg, wbData, $time);
                    compareErrors++;
                end
                else
                begin
                    checkCount++;
                    if (wbReg !== expReg[gotCount] || wbData !== expData[gotCount])
                    begin
                        $display("mismatch at %0t: write %0d expected r%0d = %h, got r%0d = %h",
                                 $time, gotCount, expReg[gotCount], expData[gotCount],
                                 wbReg, wbData);
                        compareErrors++;
                    end
                end
                gotCount++;
            end
        end
    end

    initial
    begin
        rstN          = 1'b0;
        progWe        = 1'b0;
        progAddr      = '0;
        progData      = '0;
        seed          = 32'hbba;
        progLen       = 0;
        gotCount      = 0;
        checkCount    = 0;
        compareErrors = 0;
        runErrors     = 0;
        buildProgram();
        runRef();
        loadProgram();
        cycles = 0;
        limit  = 4 * progLen + 50;
        while (gotCount < expReg.size() && cycles < limit)
        begin
            @(posedge clk);
            cycles++;
        end
        if (gotCount < expReg.size())
        begin
            $display("run timed out after %0d cycles, %0d of %0d writebacks missing",
                     cycles, expReg.size() - gotCount, expReg.size());
            runErrors++;
        end
        else
        begin
            repeat (10) @(posedge clk);   // quiet window where extras would show
        end
        $display("checks: %0d  errors: %0d", checkCount, compareErrors + runErrors);
        if (compareErrors + runErrors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// File: bench/pipelineCpu_assert.sv
`timescale 1ns/100ps

module pipelineCpu_assert
(
    input logic                              clk,
    input logic                              rstN,
    input logic                              wbValid,
    input logic [cpuPkg::REG_ADDR_WIDTH-1:0] wbReg,
    input logic                              redirect,
    input logic                              stall,
    input logic                              ifIdValid,
    input cpuPkg::idExT                      idEx
);

    wbNotR0: assert property (@(posedge clk) disable iff (!rstN)
        wbValid |-> wbReg != '0)
        else $error("writeback strobe raised for r0");

    // both younger slots flushed
    flushAfterRedirect: assert property (@(posedge clk) disable iff (!rstN)
        redirect |=> !ifIdValid && !idEx.valid)
        else $error("younger instruction survived a taken branch");

    // a hazard clears once the producer reaches MEM/WB
    stallAtMostTwo: assert property (@(posedge clk) disable iff (!rstN)
        stall ##1 stall |=> !stall)
        else $error("interlock stall lasted more than two cycles");

    stallIssuesBubble: assert property (@(posedge clk) disable iff (!rstN)
        stall |=> !idEx.valid)
        else $error("stalled cycle issued a valid instruction");

endmodule

bind pipelineCpu pipelineCpu_assert pipelineCpu_assert_inst
(
    .clk       (clk),
    .rstN      (rstN),
    .wbValid   (wbValid),
    .wbReg     (wbReg),
    .redirect  (redirect),
    .stall     (stall),
    .ifIdValid (ifId.valid),
    .idEx      (idEx)
);

// File: list.f
source/cpuPkg.sv
source/fetchStage.sv
source/decodeStage.sv
source/executeStage.sv
source/memoryStage.sv
source/pipelineCpu.sv
bench/pipelineCpu_assert.sv
bench/pipelineCpuTb.sv

// File: run.sh
#!/bin/bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module pipelineCpuTb -f list.f -o simv
./obj_dir/simv | tee sim.log

if grep -q "Test failures found" sim.log; then
    exit 1
fi
grep -q "All tests passed!" sim.log

// File: source/cpuPkg.sv
package cpuPkg;

    // datapath and storage sizes
    localparam int DATA_WIDTH      = 32;
    localparam int REG_ADDR_WIDTH  = 5;
    localparam int IMEM_WORDS      = 64;
    localparam int DMEM_WORDS      = 64;
    localparam int IMEM_ADDR_WIDTH = 6;  // word index into instruction memory
    localparam int DMEM_ADDR_WIDTH = 6;  // word index into data memory

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0]
    {
        RTYPE = 6'd0,
        BEQ   = 6'd4,
        ADDI  = 6'd8,
        LW    = 6'd35,
        SW    = 6'd43
    } opcodeT;

    // funct field under RTYPE, instr[5:0]
    typedef enum logic [5:0]
    {
        MUL = 6'd24,
        ADD = 6'd32,
        SUB = 6'd34
    } functT;

    // operation the execute ALU applies
    typedef enum logic [1:0]
    {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_MUL = 2'd2   // low half of product
    } aluOpT;

    // IF/ID register
    typedef struct packed
    {
        logic                  valid;
        logic [DATA_WIDTH-1:0] pc;
        logic [DATA_WIDTH-1:0] instr;
    } ifIdT;

    // ID/EX register
    typedef struct packed
    {
        logic                      valid;
        aluOpT                     aluOp;
        logic                      useImm;    // second operand is imm, not rt
        logic                      regWrite;
        logic                      memRead;
        logic                      memWrite;
        logic                      branch;    // beq
        logic [DATA_WIDTH-1:0]     rsValue;
        logic [DATA_WIDTH-1:0]     rtValue;
        logic [DATA_WIDTH-1:0]     imm;       // sign extended
        logic [REG_ADDR_WIDTH-1:0] dest;
        logic [DATA_WIDTH-1:0]     pc;
    } idExT;

    // EX/MEM register
    typedef struct packed
    {
        logic                      valid;
        logic [DATA_WIDTH-1:0]     result;     // alu result or byte address
        logic [DATA_WIDTH-1:0]     storeData;
        logic [REG_ADDR_WIDTH-1:0] dest;
        logic                      regWrite;
        logic                      memRead;
        logic                      memWrite;
    } exMemT;

    // MEM/WB register, also the register file write port
    typedef struct packed
    {
        logic                      valid;
        logic [REG_ADDR_WIDTH-1:0] dest;
        logic [DATA_WIDTH-1:0]     data;
    } wbT;

endpackage

// File: source/decodeStage.sv
`timescale 1ns/100ps

module decodeStage
(
    input  logic          clk,
    input  logic          rstN,
    input  cpuPkg::ifIdT  ifId,
    input  logic          redirect,
    input  cpuPkg::wbT    wb,
    input  cpuPkg::exMemT exMem,
    output cpuPkg::idExT  idEx,
    output logic          stall
);

    logic [cpuPkg::DATA_WIDTH-1:0]     regs [2**cpuPkg::REG_ADDR_WIDTH];
    cpuPkg::opcodeT                    opcode;
    cpuPkg::functT                     funct;
    logic [cpuPkg::REG_ADDR_WIDTH-1:0] rs;
    logic [cpuPkg::REG_ADDR_WIDTH-1:0] rt;
    logic [cpuPkg::REG_ADDR_WIDTH-1:0] rd;
    logic                              usesRs;
    logic                              usesRt;
    logic                              rsBusy;
    logic                              rtBusy;
    cpuPkg::idExT                      idExNext;

    // instruction fields
    assign opcode = cpuPkg::opcodeT'(ifId.instr[31:26]);
    assign rs     = ifId.instr[25:21];
    assign rt     = ifId.instr[20:16];
    assign rd     = ifId.instr[15:11];
    assign funct  = cpuPkg::functT'(ifId.instr[5:0]);

    // read port, r0 hardwired, same-cycle wb bypasses the array
    function automatic logic [cpuPkg::DATA_WIDTH-1:0] readReg
    (
        input logic [cpuPkg::REG_ADDR_WIDTH-1:0] idx
    );
        if (idx == '0)
            return '0;
        else if (wb.valid && (wb.dest == idx))
            return wb.data;
        else
            return regs[idx];
    endfunction

    // an older in-flight instruction will write src
    function automatic logic writesTo
    (
        input logic [cpuPkg::REG_ADDR_WIDTH-1:0] src,
        input logic                              valid,
        input logic                              regWrite,
        input logic [cpuPkg::REG_ADDR_WIDTH-1:0] dest
    );
        return valid && regWrite && (dest != '0) && (dest == src);
    endfunction

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < 2**cpuPkg::REG_ADDR_WIDTH; i++)
                regs[i] <= '0;    // regs start at zero
        end
        else if (wb.valid && (wb.dest != '0))
        begin
            regs[wb.dest] <= wb.data;
        end
    end

    // control decode
    always_comb
    begin
        idExNext          = '0;
        idExNext.aluOp    = cpuPkg::ALU_ADD;
        idExNext.dest     = rd;
        usesRs            = 1'b0;
        usesRt            = 1'b0;
        case (opcode)
            cpuPkg::RTYPE:
            begin
                case (funct)
                    cpuPkg::ADD: idExNext.aluOp = cpuPkg::ALU_ADD;
                    cpuPkg::SUB: idExNext.aluOp = cpuPkg::ALU_SUB;
                    cpuPkg::MUL: idExNext.aluOp = cpuPkg::ALU_MUL;
                    default:     idExNext.aluOp = cpuPkg::ALU_ADD;
                endcase
                // unknown funct stays a no-op
                usesRs            = (funct == cpuPkg::ADD) || (funct == cpuPkg::SUB) ||
                                    (funct == cpuPkg::MUL);
                usesRt            = usesRs;
                idExNext.regWrite = usesRs;
            end
            cpuPkg::ADDI:
            begin
                idExNext.useImm   = 1'b1;
                idExNext.regWrite = 1'b1;
                idExNext.dest     = rt;      // i-type writes rt
                usesRs            = 1'b1;
            end
            cpuPkg::LW:
            begin
                idExNext.useImm   = 1'b1;
                idExNext.regWrite = 1'b1;
                idExNext.memRead  = 1'b1;
                idExNext.dest     = rt;
                usesRs            = 1'b1;
            end
            cpuPkg::SW:
            begin
                idExNext.useImm   = 1'b1;
                idExNext.memWrite = 1'b1;
                usesRs            = 1'b1;
                usesRt            = 1'b1;    // store data
            end
            cpuPkg::BEQ:
            begin
                idExNext.aluOp    = cpuPkg::ALU_SUB;
                idExNext.branch   = 1'b1;
                usesRs            = 1'b1;
                usesRt            = 1'b1;
            end
            default: ;                       // unsupported opcode -> no-op
        endcase
        idExNext.rsValue = readReg(rs);
        idExNext.rtValue = readReg(rt);
        idExNext.imm     = {{(cpuPkg::DATA_WIDTH-16){ifId.instr[15]}}, ifId.instr[15:0]};
        idExNext.pc      = ifId.pc;
        idExNext.valid   = ifId.valid && !stall && !redirect;  // bubble or flush
    end

    // interlock against ID/EX and EX/MEM, MEM/WB is covered by the bypass
    assign rsBusy = writesTo(rs, idEx.valid, idEx.regWrite, idEx.dest) ||
                    writesTo(rs, exMem.valid, exMem.regWrite, exMem.dest);
    assign rtBusy = writesTo(rt, idEx.valid, idEx.regWrite, idEx.dest) ||
                    writesTo(rt, exMem.valid, exMem.regWrite, exMem.dest);
    assign stall  = ifId.valid && ((usesRs && rsBusy) || (usesRt && rtBusy));

    always_ff @(posedge clk)
    begin
        if (!rstN)
            idEx.valid <= 1'b0;
        else
            idEx <= idExNext;
    end

endmodule

// File: source/executeStage.sv
`timescale 1ns/100ps

module executeStage
(
    input  logic                          clk,
    input  logic                          rstN,
    input  cpuPkg::idExT                  idEx,
    output cpuPkg::exMemT                 exMem,
    output logic                          redirect,
    output logic [cpuPkg::DATA_WIDTH-1:0] redirectPc
);

    logic [cpuPkg::DATA_WIDTH-1:0] operandB;
    logic [cpuPkg::DATA_WIDTH-1:0] aluResult;
    logic                          operandsEqual;
    cpuPkg::exMemT                 exMemNext;

    // immediate for addi, lw, sw
    assign operandB = idEx.useImm ? idEx.imm : idEx.rtValue;

    always_comb
    begin
        case (idEx.aluOp)
            cpuPkg::ALU_SUB:
            begin
                aluResult = idEx.rsValue - operandB;
            end
            cpuPkg::ALU_MUL:
            begin
                aluResult = idEx.rsValue * operandB;  // truncates to low 32 bits
            end
            default:
            begin
                aluResult = idEx.rsValue + operandB;  // add, also address calc
            end
        endcase
    end

    // beq resolves here
    assign operandsEqual = (idEx.rsValue == idEx.rtValue);
    assign redirect      = idEx.valid && idEx.branch && operandsEqual;

    // pc + 4 + (imm << 2)
    assign redirectPc = idEx.pc + cpuPkg::DATA_WIDTH'(4) +
                        {idEx.imm[cpuPkg::DATA_WIDTH-3:0], 2'b00};

    always_comb
    begin
        exMemNext           = '0;
        exMemNext.valid     = idEx.valid;
        exMemNext.result    = aluResult;
        exMemNext.storeData = idEx.rtValue;       // sw data from rt
        exMemNext.dest      = idEx.dest;
        exMemNext.regWrite  = idEx.regWrite;      // clear for beq and sw
        exMemNext.memRead   = idEx.memRead;
        exMemNext.memWrite  = idEx.memWrite;
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
            exMem.valid <= 1'b0;
        else
            exMem <= exMemNext;
    end

endmodule

// File: source/fetchStage.sv
`timescale 1ns/100ps

module fetchStage
(
    input  logic                               clk,
    input  logic                               rstN,
    input  logic                               stall,
    input  logic                               redirect,
    input  logic [cpuPkg::DATA_WIDTH-1:0]      redirectPc,
    input  logic                               progWe,
    input  logic [cpuPkg::IMEM_ADDR_WIDTH-1:0] progAddr,
    input  logic [cpuPkg::DATA_WIDTH-1:0]      progData,
    output cpuPkg::ifIdT                       ifId
);

    logic [cpuPkg::DATA_WIDTH-1:0]      imem [cpuPkg::IMEM_WORDS];
    logic [cpuPkg::DATA_WIDTH-1:0]      pc;
    logic [cpuPkg::IMEM_ADDR_WIDTH:0]   progLen;   // one past last loaded word
    logic [cpuPkg::IMEM_ADDR_WIDTH-1:0] pcWord;
    logic                               pastEnd;
    logic [cpuPkg::DATA_WIDTH-1:0]      fetchWord;

    // program load port, used while core is in reset
    always_ff @(posedge clk)
    begin
        if (progWe)
        begin
            imem[progAddr] <= progData;
            progLen <= {1'b0, progAddr} + (cpuPkg::IMEM_ADDR_WIDTH + 1)'(1); // ascending load
        end
    end

    assign pcWord = pc[cpuPkg::IMEM_ADDR_WIDTH+1:2];  // byte pc to word index

    // beyond the program, or beyond the array
    assign pastEnd = (pc[cpuPkg::DATA_WIDTH-1:cpuPkg::IMEM_ADDR_WIDTH+2] != '0) ||
                     ({1'b0, pcWord} >= progLen);

    // zero word is sll r0 -> no-op
    assign fetchWord = pastEnd ? '0 : imem[pcWord];

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            pc         <= '0;
            ifId.valid <= 1'b0;
        end
        else if (redirect)
        begin
            // taken branch, drop the word being fetched
            pc         <= redirectPc;
            ifId.valid <= 1'b0;
        end
        else if (!stall)
        begin
            pc         <= pc + cpuPkg::DATA_WIDTH'(4);
            ifId.valid <= 1'b1;
            ifId.pc    <= pc;
            ifId.instr <= fetchWord;
        end
        // stall: pc and IF/ID hold
    end

endmodule

// File: source/memoryStage.sv
`timescale 1ns/100ps

module memoryStage
(
    input  logic          clk,
    input  logic          rstN,
    input  cpuPkg::exMemT exMem,
    output cpuPkg::wbT    wb
);

    logic [cpuPkg::DATA_WIDTH-1:0]      dmem [cpuPkg::DMEM_WORDS];
    logic [cpuPkg::DMEM_ADDR_WIDTH-1:0] wordIndex;
    logic [cpuPkg::DATA_WIDTH-1:0]      loadData;
    cpuPkg::wbT                         wbNext;

    // byte address, low two bits dropped, upper bits wrap
    assign wordIndex = exMem.result[cpuPkg::DMEM_ADDR_WIDTH+1:2];
    assign loadData  = dmem[wordIndex];   // async read

    always_ff @(posedge clk)
    begin
        if (!rstN)
        begin
            for (int i = 0; i < cpuPkg::DMEM_WORDS; i++)
                dmem[i] <= '0;              // unwritten words load as zero
        end
        else if (exMem.valid && exMem.memWrite)
        begin
            dmem[wordIndex] <= exMem.storeData;
        end
    end

    // r0 writes vanish here
    always_comb
    begin
        wbNext       = '0;
        wbNext.valid = exMem.valid && exMem.regWrite && (exMem.dest != '0);
        wbNext.dest  = exMem.dest;
        wbNext.data  = exMem.memRead ? loadData : exMem.result;
    end

    always_ff @(posedge clk)
    begin
        if (!rstN)
            wb.valid <= 1'b0;
        else
            wb <= wbNext;
    end

endmodule

// File: source/pipelineCpu.sv
`timescale 1ns/100ps

module pipelineCpu
(
    input  logic                               clk,
    input  logic                               rstN,
    input  logic                               progWe,
    input  logic [cpuPkg::IMEM_ADDR_WIDTH-1:0] progAddr,
    input  logic [cpuPkg::DATA_WIDTH-1:0]      progData,
    output logic                               wbValid,
    output logic [cpuPkg::REG_ADDR_WIDTH-1:0]  wbReg,
    output logic [cpuPkg::DATA_WIDTH-1:0]      wbData
);

    cpuPkg::ifIdT                  ifId;
    cpuPkg::idExT                  idEx;
    cpuPkg::exMemT                 exMem;
    cpuPkg::wbT                    wb;
    logic                          stall;       // decode interlock
    logic                          redirect;    // taken beq
    logic [cpuPkg::DATA_WIDTH-1:0] redirectPc;

    fetchStage fetchStage_inst
    (
        .clk        (clk),
        .rstN       (rstN),
        .stall      (stall),
        .redirect   (redirect),
        .redirectPc (redirectPc),
        .progWe     (progWe),
        .progAddr   (progAddr),
        .progData   (progData),
        .ifId       (ifId)
    );

    decodeStage decodeStage_inst
    (
        .clk      (clk),
        .rstN     (rstN),
        .ifId     (ifId),
        .redirect (redirect),
        .wb       (wb),
        .exMem    (exMem),
        .idEx     (idEx),
        .stall    (stall)
    );

    executeStage executeStage_inst
    (
        .clk        (clk),
        .rstN       (rstN),
        .idEx       (idEx),
        .exMem      (exMem),
        .redirect   (redirect),
        .redirectPc (redirectPc)
    );

    memoryStage memoryStage_inst
    (
        .clk   (clk),
        .rstN  (rstN),
        .exMem (exMem),
        .wb    (wb)
    );

    // writeback strobe, same as the regfile write
    assign wbValid = wb.valid;
    assign wbReg   = wb.dest;
    assign wbData  = wb.data;

endmodule
